/* compile.f */
common/procPkg.sv
decode/regFile.sv
decode/decode.sv
fetch/fetch.sv
hdl/control.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
testbench/proc_properties.sv
testbench/procTb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - common/procPkg.sv
  - decode/regFile.sv
  - decode/decode.sv
  - fetch/fetch.sv
  - hdl/control.sv
  - hdl/execute.sv
  - hdl/memory.sv
  - hdl/proc.sv
  - target: test
    files:
      - testbench/proc_properties.sv
      - testbench/procTb.sv

/* testbench/procTb.sv */
// Testbench for proc with clock, reset, program table, loader, trace checks and final report
`timescale 1ns/1ps
`default_nettype none

module procTb;

   localparam int numRows        = 24;
   localparam int resetCycles    = 5;
   localparam int postHaltCycles = 4;
   // Four cycles per row, plus the load and reset time
   localparam int watchdogCycles = numRows * 4 + (numRows + resetCycles + 1);

   logic              clk;
   logic              reset;
   logic              imemWrEn;
   logic [7:0]        imemAddr;
   procPkg::word_t    imemData;
   logic              regWrEn;
   procPkg::regAddr_t regWrAddr;
   procPkg::word_t    regWrData;
   logic              halted;
   logic              err;

   // Program table, rows in execution order
   logic [7:0]        rowAddr   [numRows];   // Word index in imem
   procPkg::word_t    rowInstr  [numRows];
   logic              rowRun    [numRows];   // Low for skipped slots
   logic              rowWrEn   [numRows];
   procPkg::regAddr_t rowWrReg  [numRows];
   procPkg::word_t    rowWrData [numRows];
   logic              rowErr    [numRows];

   int rowCount = 0;
   int curRow   = 0;
   int errors   = 0;

   proc #(
      .imemAddrBits(8),
      .dmemAddrBits(8)
   ) uut (
      .clk(clk), .reset(reset),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
      .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // Instruction encoders
   function automatic procPkg::word_t iForm(procPkg::opcode_e op, procPkg::regAddr_t rs,
                                            procPkg::regAddr_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic procPkg::word_t rForm(procPkg::regAddr_t rs, procPkg::regAddr_t rt,
                                            procPkg::regAddr_t rd, procPkg::aluOp_e fn);
      return {procPkg::OpRtype, rs, rt, rd, fn};
   endfunction

   function automatic procPkg::word_t bForm(procPkg::opcode_e op, procPkg::regAddr_t rs,
                                            logic [7:0] imm);
      return {op, rs, imm};    // lbi, beqz, bnez
   endfunction

   function automatic procPkg::word_t jForm(procPkg::opcode_e op, logic [10:0] imm);
      return {op, imm};
   endfunction

   task automatic addRow(input logic [7:0] addr, input procPkg::word_t instr, input logic run,
                         input logic wrEn, input procPkg::regAddr_t wrReg,
                         input procPkg::word_t wrData, input logic isErr);
      rowAddr[rowCount]   = addr;
      rowInstr[rowCount]  = instr;
      rowRun[rowCount]    = run;
      rowWrEn[rowCount]   = wrEn;
      rowWrReg[rowCount]  = wrReg;
      rowWrData[rowCount] = wrData;
      rowErr[rowCount]    = isErr;
      rowCount++;
   endtask

   task automatic checkWord(input string name, input procPkg::word_t exp,
                            input procPkg::word_t got);
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s at row %0d: expected 0x%h, observed 0x%h", name, curRow, exp, got);
      end
   endtask

   task automatic checkReg(input string name, input procPkg::regAddr_t exp,
                           input procPkg::regAddr_t got);
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s at row %0d: expected 0x%h, observed 0x%h", name, curRow, exp, got);
      end
   endtask

   task automatic checkBit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s at row %0d: expected 0x%h, observed 0x%h", name, curRow, exp, got);
      end
   endtask

   // Expected values worked out by hand
   task automatic buildProgram();
      addRow(8'h00, bForm(procPkg::OpLbi, 3'd1, 8'h25), 1, 1, 3'd1, 16'h0025, 0);
      addRow(8'h01, bForm(procPkg::OpLbi, 3'd2, 8'hFD), 1, 1, 3'd2, 16'hFFFD, 0);  // Negative
      addRow(8'h02, iForm(procPkg::OpAddi, 3'd1, 3'd3, 5'h1C), 1, 1, 3'd3, 16'h0021, 0);
      addRow(8'h03, iForm(procPkg::OpSubi, 3'd1, 3'd4, 5'h05), 1, 1, 3'd4, 16'hFFE0, 0);
      addRow(8'h04, iForm(procPkg::OpXori, 3'd2, 3'd5, 5'h1F), 1, 1, 3'd5, 16'hFFE2, 0);
      addRow(8'h05, iForm(procPkg::OpAndni, 3'd2, 3'd6, 5'h10), 1, 1, 3'd6, 16'hFFED, 0);
      addRow(8'h06, rForm(3'd1, 3'd2, 3'd3, procPkg::AluAdd), 1, 1, 3'd3, 16'h0022, 0);
      addRow(8'h07, rForm(3'd1, 3'd2, 3'd4, procPkg::AluSub), 1, 1, 3'd4, 16'hFFD8, 0);
      addRow(8'h08, rForm(3'd1, 3'd6, 3'd5, procPkg::AluXor), 1, 1, 3'd5, 16'hFFC8, 0);
      addRow(8'h09, rForm(3'd2, 3'd3, 3'd6, procPkg::AluAndn), 1, 1, 3'd6, 16'hFFDD, 0);
      addRow(8'h0A, iForm(procPkg::OpSt, 3'd1, 3'd5, 5'h03), 1, 0, 3'd0, 16'h0000, 0);
      addRow(8'h0B, iForm(procPkg::OpLd, 3'd3, 3'd4, 5'h06), 1, 1, 3'd4, 16'hFFC8, 0);
      addRow(8'h0C, bForm(procPkg::OpBeqz, 3'd0, 8'h02), 1, 0, 3'd0, 16'h0000, 0);  // Taken
      addRow(8'h0D, iForm(procPkg::OpAddi, 3'd1, 3'd1, 5'h01), 0, 0, 3'd0, 16'h0000, 0);
      addRow(8'h0E, bForm(procPkg::OpBnez, 3'd2, 8'h02), 1, 0, 3'd0, 16'h0000, 0);  // Taken
      addRow(8'h0F, iForm(procPkg::OpAddi, 3'd2, 3'd2, 5'h01), 0, 0, 3'd0, 16'h0000, 0);
      addRow(8'h10, bForm(procPkg::OpBeqz, 3'd1, 8'h02), 1, 0, 3'd0, 16'h0000, 0);  // Falls
      addRow(8'h11, bForm(procPkg::OpBnez, 3'd0, 8'h04), 1, 0, 3'd0, 16'h0000, 0);  // Falls
      addRow(8'h12, jForm(procPkg::OpJal, 11'h006), 1, 1, 3'd7, 16'h0026, 0);  // To 0x2C
      addRow(8'h16, 16'hF800, 1, 0, 3'd0, 16'h0000, 1);                         // Undefined
      addRow(8'h17, iForm(procPkg::OpAddi, 3'd1, 3'd1, 5'h01), 1, 1, 3'd1, 16'h0026, 0);
      addRow(8'h18, iForm(procPkg::OpJr, 3'd7, 3'd0, 5'h00), 1, 0, 3'd0, 16'h0000, 0);
      addRow(8'h13, iForm(procPkg::OpAddi, 3'd4, 3'd2, 5'h02), 1, 1, 3'd2, 16'hFFCA, 0);
      addRow(8'h14, jForm(procPkg::OpHalt, 11'h000), 1, 0, 3'd0, 16'h0000, 0);
   endtask

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      reset    = 1'b1;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      buildProgram();
      if (rowCount != numRows) begin
         errors++;
         $display("Program table holds %0d rows instead of %0d", rowCount, numRows);
      end
      // Load port, one word per cycle under reset
      for (int r = 0; r < numRows; r++) begin
         @(posedge clk);
         #1;
         imemWrEn = 1'b1;
         imemAddr = rowAddr[r];
         imemData = rowInstr[r];
      end
      @(posedge clk);
      #1;
      imemWrEn = 1'b0;
      repeat (resetCycles) @(posedge clk);   // Reset held five cycles past the load
      #1;
      reset = 1'b0;
      // One executed row per cycle, sampled mid-cycle
      for (int r = 0; r < numRows; r++) begin
         if (rowRun[r]) begin
            curRow = r;
            @(negedge clk);
            checkBit("regWrEn", rowWrEn[r], regWrEn);
            if (rowWrEn[r]) begin
               checkReg("regWrAddr", rowWrReg[r], regWrAddr);
               checkWord("regWrData", rowWrData[r], regWrData);
            end
            checkBit("err", rowErr[r], err);
            checkBit("halted", 1'b0, halted);
         end
      end
      curRow = numRows;
      repeat (postHaltCycles) begin
         @(negedge clk);
         checkBit("halted", 1'b1, halted);      // Sticky
         checkBit("regWrEn", 1'b0, regWrEn);
      end
      $display("Trace checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/proc_properties.sv */
// Bound assertions on proc for reset state, halt stickiness and register-write rules
`timescale 1ns/1ps
`default_nettype none

module procProperties (
   input logic              clk,
   input logic              reset,
   input logic              halted,
   input logic              err,
   input logic              regWrEn,
   input procPkg::regAddr_t regWrAddr,
   input procPkg::word_t    instr
);

   // First cycle out of reset
   resetState: assert property (@(posedge clk) $fell(reset) |-> !halted && !err)
      else $error("halted or err high in the first cycle after reset");

   haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else $error("halted dropped before reset");

   noWriteHalted: assert property (@(posedge clk) disable iff (reset) halted |-> !regWrEn)
      else $error("register write while halted");

   // Link register is r7
   jalLink: assert property (@(posedge clk) disable iff (reset)
      (regWrEn && instr[15:11] == procPkg::OpJal) |-> regWrAddr == 3'd7)
      else $error("jal wrote a register other than r7");

endmodule

bind proc procProperties props (
   .clk(clk), .reset(reset), .halted(halted), .err(err),
   .regWrEn(regWrEn), .regWrAddr(regWrAddr), .instr(instr)
);

`default_nettype wire

/* hdl/proc.sv */
// Processor top level connecting fetch, decode, control, execute and memory stages
`timescale 1ns/1ps
`default_nettype none

module proc #(
   parameter int imemAddrBits = 8,
   parameter int dmemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    imemWrEn,
   input  logic [imemAddrBits-1:0] imemAddr,
   input  procPkg::word_t          imemData,
   output logic                    regWrEn,
   output procPkg::regAddr_t       regWrAddr,
   output procPkg::word_t          regWrData,
   output logic                    halted,
   output logic                    err
);

   procPkg::word_t instr, pc, immExt, rsData, rtData, aluOut, writeback;
   logic zero, sign;

   // Control lines
   logic pcSel, regJmp, halt;                    // Fetch
   logic regWrite, iFormat, lbi, link, store;    // Decode
   logic aluSel;                                 // Execute
   logic memEnable, memWr, val2Reg;              // Memory
   procPkg::aluOp_e   aluOp;
   procPkg::immKind_e immKind;

   fetch #(.imemAddrBits(imemAddrBits)) fetchStage (
      .clk(clk), .reset(reset), .halt(halt), .pcSel(pcSel), .regJmp(regJmp),
      .immExt(immExt), .rsData(rsData),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .Instr(instr), .PC(pc), .halted(halted)
   );

   decode decodeStage (
      .clk(clk), .reset(reset), .Instr(instr), .PC(pc), .Writeback(writeback),
      .regWrite(regWrite), .lbi(lbi), .link(link), .iFormat(iFormat), .store(store),
      .immKind(immKind), .rsData(rsData), .rtData(rtData), .immExt(immExt),
      .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData)
   );

   control ctrl (
      .opcode(procPkg::opcode_e'(instr[15:11])), .funct(procPkg::aluOp_e'(instr[1:0])),
      .zero(zero), .sign(sign),
      .regWrite(regWrite), .iFormat(iFormat), .lbi(lbi), .link(link), .store(store),
      .pcSel(pcSel), .regJmp(regJmp), .halt(halt),
      .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .aluSel(aluSel),
      .aluOp(aluOp), .immKind(immKind), .err(err)
   );

   execute exStage (
      .rsData(rsData), .rtData(rtData), .immExt(immExt), .aluSel(aluSel), .aluOp(aluOp),
      .aluOut(aluOut), .zero(zero), .sign(sign)
   );

   // Writeback select lives here too
   memory #(.dmemAddrBits(dmemAddrBits)) memStage (
      .clk(clk), .reset(reset), .addr(aluOut), .dataIn(rtData),
      .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .Writeback(writeback)
   );

endmodule

`default_nettype wire

/* hdl/memory.sv */
// Data memory with sync write and writeback select between ALU result and load data
`timescale 1ns/1ps
`default_nettype none

module memory #(
   parameter int dmemAddrBits = 8
) (
   input  logic           clk,
   input  logic           reset,
   input  procPkg::word_t addr,
   input  procPkg::word_t dataIn,
   input  logic           memEnable,
   input  logic           memWr,
   input  logic           val2Reg,
   output procPkg::word_t Writeback
);

   procPkg::word_t dmem [2**dmemAddrBits];
   logic [dmemAddrBits-1:0] wordIdx;

   assign wordIdx = addr[dmemAddrBits:1];    // Word addressed

   // Load data returns in the same cycle
   assign Writeback = val2Reg ? dmem[wordIdx] : addr;

   always_ff @(posedge clk) begin
      if (memEnable && memWr && !reset)     // No stores during reset
         dmem[wordIdx] <= dataIn;
   end

endmodule

`default_nettype wire

/* hdl/execute.sv */
// ALU with second-operand select and zero and sign flags
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  procPkg::word_t  rsData,
   input  procPkg::word_t  rtData,
   input  procPkg::word_t  immExt,
   input  logic            aluSel,
   input  procPkg::aluOp_e aluOp,
   output procPkg::word_t  aluOut,
   output logic            zero,
   output logic            sign
);

   procPkg::word_t opB;

   assign opB = aluSel ? immExt : rtData;   // Immediate or Rt

   always_comb begin
      case (aluOp)
         procPkg::AluAdd:  aluOut = rsData + opB;
         procPkg::AluSub:  aluOut = opB - rsData;    // Reversed operands
         procPkg::AluXor:  aluOut = rsData ^ opB;
         procPkg::AluAndn: aluOut = rsData & ~opB;
         default:          aluOut = '0;
      endcase
   end

   // Flags from the result
   assign zero = (aluOut == '0);
   assign sign = aluOut[15];

endmodule

`default_nettype wire

/* hdl/control.sv */
// Main decoder with enables, selects, ALU operation, branch resolution and illegal-opcode trap
`timescale 1ns/1ps
`default_nettype none

module control (
   input  procPkg::opcode_e  opcode,
   input  procPkg::aluOp_e   funct,
   input  logic              zero,
   input  logic              sign,
   output logic              regWrite,
   output logic              iFormat,
   output logic              lbi,
   output logic              link,
   output logic              store,
   output logic              pcSel,
   output logic              regJmp,
   output logic              halt,
   output logic              memEnable,
   output logic              memWr,
   output logic              val2Reg,
   output logic              aluSel,
   output procPkg::aluOp_e   aluOp,
   output procPkg::immKind_e immKind,
   output logic              err
);

   always_comb begin
      // Defaults act as a nop
      regWrite  = 1'b0;
      iFormat   = 1'b1;    // Only R-type clears it
      lbi       = 1'b0;
      link      = 1'b0;
      store     = 1'b0;
      pcSel     = 1'b0;
      regJmp    = 1'b0;
      halt      = 1'b0;
      memEnable = 1'b0;
      memWr     = 1'b0;
      val2Reg   = 1'b0;
      aluSel    = 1'b1;    // Immediate operand
      aluOp     = procPkg::AluAdd;
      immKind   = procPkg::ImmSign5;
      err       = 1'b0;
      case (opcode)
         procPkg::OpHalt: halt = 1'b1;
         procPkg::OpNop: ;
         procPkg::OpAddi: regWrite = 1'b1;
         procPkg::OpSubi: begin
            regWrite = 1'b1;
            aluOp    = procPkg::AluSub;   // imm - Rs
         end
         procPkg::OpXori, procPkg::OpAndni: begin
            regWrite = 1'b1;
            immKind  = procPkg::ImmZero5;
            aluOp    = (opcode == procPkg::OpXori) ? procPkg::AluXor : procPkg::AluAndn;
         end
         procPkg::OpRtype: begin
            regWrite = 1'b1;
            iFormat  = 1'b0;
            aluSel   = 1'b0;
            aluOp    = funct;
         end
         procPkg::OpLbi: begin
            regWrite = 1'b1;
            lbi      = 1'b1;
            immKind  = procPkg::ImmSign8;
         end
         procPkg::OpSt: begin
            store     = 1'b1;
            memEnable = 1'b1;
            memWr     = 1'b1;
         end
         procPkg::OpLd: begin
            regWrite  = 1'b1;
            memEnable = 1'b1;
            val2Reg   = 1'b1;
         end
         procPkg::OpBeqz, procPkg::OpBnez: begin
            immKind = procPkg::ImmSign8;
            aluSel  = 1'b0;                 // rtData is zero here
            aluOp   = procPkg::AluAndn;     // Rs passes unchanged
            // Negative implies nonzero
            pcSel   = (opcode == procPkg::OpBeqz) ? zero : (sign || !zero);
         end
         procPkg::OpJ: begin
            pcSel   = 1'b1;
            immKind = procPkg::ImmSign11;
         end
         procPkg::OpJal: begin
            pcSel    = 1'b1;
            link     = 1'b1;
            regWrite = 1'b1;                // PC + 2 into r7
            immKind  = procPkg::ImmSign11;
         end
         procPkg::OpJr: regJmp = 1'b1;     // Rs + imm5
         default: err = 1'b1;              // Undefined opcode, behaves as nop
      endcase
   end

endmodule

`default_nettype wire

/* fetch/fetch.sv */
// Fetch stage with program counter, next-PC select, halt latch and instruction memory
`timescale 1ns/1ps
`default_nettype none

module fetch #(
   parameter int imemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    halt,
   input  logic                    pcSel,
   input  logic                    regJmp,
   input  procPkg::word_t          immExt,
   input  procPkg::word_t          rsData,
   input  logic                    imemWrEn,
   input  logic [imemAddrBits-1:0] imemAddr,
   input  procPkg::word_t          imemData,
   output procPkg::word_t          Instr,
   output procPkg::word_t          PC,
   output logic                    halted
);

   procPkg::word_t imem [2**imemAddrBits];  // Program store
   procPkg::word_t pcInc;
   procPkg::word_t pcNext;

   assign pcInc = PC + 16'd2;
   assign Instr = imem[PC[imemAddrBits:1]];  // Async read, word index

   always_comb begin
      pcNext = pcInc;                 // Fall through
      if (halt || halted)
         pcNext = PC;                 // Hold on halt and after
      else if (regJmp)
         pcNext = rsData + immExt;    // jr
      else if (pcSel)
         pcNext = pcInc + immExt;     // Taken branch, j, jal
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         PC     <= '0;
         halted <= 1'b0;
      end else begin
         PC <= pcNext;
         if (halt)
            halted <= 1'b1;           // Sticky until reset
      end
   end

   // Load port from the testbench
   always_ff @(posedge clk) begin
      if (imemWrEn)
         imem[imemAddr] <= imemData;
   end

endmodule

`default_nettype wire

/* decode/decode.sv */
// Decode stage with register file, immediate extension, destination and write-value select
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic               clk,
   input  logic               reset,
   input  procPkg::word_t     Instr,
   input  procPkg::word_t     PC,
   input  procPkg::word_t     Writeback,
   input  logic               regWrite,
   input  logic               lbi,
   input  logic               link,
   input  logic               iFormat,
   input  logic               store,
   input  procPkg::immKind_e  immKind,
   output procPkg::word_t     rsData,
   output procPkg::word_t     rtData,
   output procPkg::word_t     immExt,
   output logic               regWrEn,
   output procPkg::regAddr_t  regWrAddr,
   output procPkg::word_t     regWrData
);

   procPkg::word_t rdData2;

   regFile rf (
      .clk     (clk),
      .reset   (reset),
      .rdAddr1 (Instr[10:8]),   // Rs
      .rdAddr2 (Instr[7:5]),    // Rt, or Rd of a store
      .wrAddr  (regWrAddr),
      .wrEn    (regWrEn),
      .wrData  (regWrData),
      .rdData1 (rsData),
      .rdData2 (rdData2)
   );

   // Port 2 only for R-type and stores, zero lets the ALU pass Rs through
   assign rtData = (store || !iFormat) ? rdData2 : '0;

   always_comb begin
      case (immKind)
         procPkg::ImmSign5:  immExt = {{11{Instr[4]}}, Instr[4:0]};
         procPkg::ImmZero5:  immExt = {11'b0, Instr[4:0]};
         procPkg::ImmSign8:  immExt = {{8{Instr[7]}}, Instr[7:0]};
         procPkg::ImmSign11: immExt = {{5{Instr[10]}}, Instr[10:0]};
         default:            immExt = '0;
      endcase
   end

   // Destination register
   always_comb begin
      if (link)
         regWrAddr = 3'd7;          // jal
      else if (lbi)
         regWrAddr = Instr[10:8];   // lbi writes Rs
      else if (iFormat)
         regWrAddr = Instr[7:5];
      else
         regWrAddr = Instr[4:2];    // R-format Rd
   end

   assign regWrData = link ? PC + 16'd2 : (lbi ? immExt : Writeback);
   assign regWrEn   = regWrite;

endmodule

`default_nettype wire

/* decode/regFile.sv */
// Eight-entry register file with two async read ports and one sync write port
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic              clk,
   input  logic              reset,
   input  procPkg::regAddr_t rdAddr1,
   input  procPkg::regAddr_t rdAddr2,
   input  procPkg::regAddr_t wrAddr,
   input  logic              wrEn,
   input  procPkg::word_t    wrData,
   output procPkg::word_t    rdData1,
   output procPkg::word_t    rdData2
);

   procPkg::word_t regs [8];

   // No write bypass
   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

   always_ff @(posedge clk) begin
      if (reset)
         regs <= '{default: '0};
      else if (wrEn)
         regs[wrAddr] <= wrData;
   end

endmodule

`default_nettype wire

/* common/procPkg.sv */
// Shared word and register-index types plus opcode, ALU-operation and immediate-kind enums
`default_nettype none

package procPkg;

   typedef logic [15:0] word_t;     // Data and address word
   typedef logic [2:0]  regAddr_t;  // Eight registers

   // Instruction bits 15 to 11
   typedef enum logic [4:0] {
      OpHalt  = 5'b00000,
      OpNop   = 5'b00001,
      OpJ     = 5'b00100,
      OpJr    = 5'b00101,
      OpJal   = 5'b00110,
      OpAddi  = 5'b01000,
      OpSubi  = 5'b01001,
      OpXori  = 5'b01010,
      OpAndni = 5'b01011,
      OpBeqz  = 5'b01100,
      OpBnez  = 5'b01101,
      OpSt    = 5'b10000,
      OpLd    = 5'b10001,
      OpLbi   = 5'b11000,
      OpRtype = 5'b11011
   } opcode_e;

   // Also the R-type function code in bits 1 to 0
   typedef enum logic [1:0] {
      AluAdd  = 2'b00,
      AluSub  = 2'b01,  // Second operand minus Rs
      AluXor  = 2'b10,
      AluAndn = 2'b11   // Rs and not second operand
   } aluOp_e;

   typedef enum logic [1:0] {
      ImmSign5  = 2'b00,
      ImmZero5  = 2'b01,  // xori, andni
      ImmSign8  = 2'b10,
      ImmSign11 = 2'b11
   } immKind_e;

endpackage

`default_nettype wire
